/* design/ps2_frame_receiver.sv */
`timescale 1ns/1ps

module ps2_frame_receiver #(
  parameter int idle_timeout_cycles = 1200
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ps2_clk,
  input  logic                    ps2_data,
  output logic                    frame_done,
  output ps2_kbd_pkg::scan_code_t frame_code
);

  import ps2_kbd_pkg::*;

  // wide enough to hold the timeout value itself
  localparam int idle_count_bits = $clog2(idle_timeout_cycles + 1);

  logic                       ps2_clk_s;
  logic                       ps2_data_s;
  line_state_e                line_state;
  line_state_e                line_state_next;
  logic                       bit_strobe;
  frame_t                     shift_reg;
  bit_count_t                 bit_count;
  logic [idle_count_bits-1:0] idle_count;
  logic                       idle_expired;

  // --------------------------------------------------------------------------
  // input synchronizers
  // --------------------------------------------------------------------------

  // both lines are slow open-drain signals with pullups, so one flop each
  // is enough to keep the state machine from seeing a half-settled level
  // the clock flop starts high so the end of reset never looks like an edge
  always_ff @(posedge clk)
  begin
    if (reset)
      ps2_clk_s <= 1'b1;
    else
      ps2_clk_s <= ps2_clk;
  end

  always_ff @(posedge clk)
  begin
    ps2_data_s <= ps2_data;
  end

  // --------------------------------------------------------------------------
  // keyboard clock tracking
  // --------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      line_state <= clock_high;
    else
      line_state <= line_state_next;
  end

  // each mark state lasts exactly one cycle and then settles into the level
  // that the line went to
  always_comb
  begin
    line_state_next = line_state;
    case (line_state)
      clock_high:
        if (!ps2_clk_s)
          line_state_next = falling_mark;
      falling_mark:
        line_state_next = clock_low;
      clock_low:
        if (ps2_clk_s)
          line_state_next = rising_mark;
      rising_mark:
        line_state_next = clock_high;
      default:
        line_state_next = clock_high;
    endcase
  end

  // the keyboard sets up data while its clock is high, so the bit is taken
  // in the cycle that marks the falling edge
  assign bit_strobe = (line_state == falling_mark);

  // --------------------------------------------------------------------------
  // idle watchdog
  // --------------------------------------------------------------------------

  // counts only while the keyboard clock sits high and stops at the limit
  // a clock that stays high this long means the frame was broken off, for
  // example by unplugging the keyboard in the middle of a byte
  always_ff @(posedge clk)
  begin
    if (reset || line_state != clock_high)
      idle_count <= '0;
    else if (!idle_expired)
      idle_count <= idle_count + 1'b1;
  end

  assign idle_expired = (line_state == clock_high) &&
                        (idle_count == idle_count_bits'(idle_timeout_cycles));

  // --------------------------------------------------------------------------
  // bit counter and shift register
  // --------------------------------------------------------------------------

  // the count clears in the cycle after the last bit, while frame_done is up
  always_ff @(posedge clk)
  begin
    if (reset || frame_done || idle_expired)
      bit_count <= '0;
    else if (bit_strobe)
      bit_count <= bit_count + 1'b1;
  end

  // bits enter at the top and move down, so after eleven shifts the start
  // bit ends up at bit 0 and the data byte at bits 8 to 1
  always_ff @(posedge clk)
  begin
    if (idle_expired)
      shift_reg <= '0;
    else if (bit_strobe)
      shift_reg <= {ps2_data_s, shift_reg[frame_bits-1:1]};
  end

  assign frame_done = (bit_count == bit_count_t'(frame_bits));

  // parity and stop bits are carried along but not checked
  assign frame_code = shift_reg[8:1];

  // the count must be cleared by frame_done before another bit can arrive
  a_bit_count_in_range: assert property (
    @(posedge clk) disable iff (reset)
    bit_count <= bit_count_t'(frame_bits)
  );

endmodule

/* design/ps2_kbd_pkg.sv */
package ps2_kbd_pkg;

  // --------------------------------------------------------------------------
  // frame layout
  // --------------------------------------------------------------------------

  // one frame from the keyboard is a start bit, eight data bits sent LSB
  // first, an odd parity bit and a stop bit
  localparam int frame_bits = 11;

  // one byte as sent by the keyboard
  typedef logic [7:0] scan_code_t;

  // the whole frame as it sits in the shift register once all bits are in,
  // with the start bit at bit 0 and the stop bit at the top
  typedef logic [frame_bits-1:0] frame_t;

  // received bit count, runs from 0 up to frame_bits and no further
  typedef logic [3:0] bit_count_t;

  // --------------------------------------------------------------------------
  // scan codes that need special handling
  // --------------------------------------------------------------------------

  // prefix sent ahead of the keys that were added on the extended keyboard
  localparam scan_code_t extend_code = 8'hE0;

  // prefix sent ahead of the code of a key that is let go
  localparam scan_code_t release_code = 8'hF0;

  // the two shift keys are tracked into one shift level
  localparam scan_code_t left_shift_code  = 8'h12;
  localparam scan_code_t right_shift_code = 8'h59;

  // --------------------------------------------------------------------------
  // state machines
  // --------------------------------------------------------------------------

  // follows the synchronized keyboard clock; the two marks last one cycle
  // each and flag an edge of the keyboard clock
  typedef enum logic [1:0] {
    clock_high,
    clock_low,
    falling_mark,
    rising_mark
  } line_state_e;

  // the host side of the receiver, holding means a code waits to be read
  typedef enum logic {
    idle,
    holding
  } ready_state_e;

endpackage

/* design/ps2_kbd_rx.sv */
`timescale 1ns/1ps

module ps2_kbd_rx #(
  parameter int idle_timeout_cycles = 1200,
  parameter bit trap_shift_keys     = 1'b0
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ps2_clk,
  input  logic                    ps2_data,
  input  logic                    rx_read,
  output ps2_kbd_pkg::scan_code_t rx_scan_code,
  output logic                    rx_extended,
  output logic                    rx_released,
  output logic                    rx_shift_key_on,
  output logic                    rx_data_ready
);

  import ps2_kbd_pkg::*;

  logic       frame_done;
  scan_code_t frame_code;
  logic       report_strobe;
  scan_code_t report_code;
  logic       report_extended;
  logic       report_released;

  // serial frames in, one byte per completed frame out
  ps2_frame_receiver #(
    .idle_timeout_cycles (idle_timeout_cycles)
  ) i_frame_receiver (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .frame_done (frame_done),
    .frame_code (frame_code)
  );

  // folds prefixes into flags and follows the shift keys
  scan_code_decoder #(
    .trap_shift_keys (trap_shift_keys)
  ) i_scan_code_decoder (
    .clk             (clk),
    .reset           (reset),
    .frame_done      (frame_done),
    .frame_code      (frame_code),
    .report_strobe   (report_strobe),
    .report_code     (report_code),
    .report_extended (report_extended),
    .report_released (report_released),
    .shift_key_on    (rx_shift_key_on)
  );

  // holds the last report for the host until it is read
  rx_output_register i_rx_output_register (
    .clk             (clk),
    .reset           (reset),
    .report_strobe   (report_strobe),
    .report_code     (report_code),
    .report_extended (report_extended),
    .report_released (report_released),
    .rx_read         (rx_read),
    .rx_scan_code    (rx_scan_code),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_data_ready   (rx_data_ready)
  );

endmodule

/* design/rx_output_register.sv */
`timescale 1ns/1ps

module rx_output_register (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    report_strobe,
  input  ps2_kbd_pkg::scan_code_t report_code,
  input  logic                    report_extended,
  input  logic                    report_released,
  input  logic                    rx_read,
  output ps2_kbd_pkg::scan_code_t rx_scan_code,
  output logic                    rx_extended,
  output logic                    rx_released,
  output logic                    rx_data_ready
);

  import ps2_kbd_pkg::*;

  ready_state_e ready_state;
  ready_state_e ready_state_next;

  // --------------------------------------------------------------------------
  // output registers
  // --------------------------------------------------------------------------

  // there is no queue, a newer report simply replaces one not yet read
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_scan_code <= '0;
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
    end
    else if (report_strobe)
    begin
      rx_scan_code <= report_code;
      rx_extended  <= report_extended;
      rx_released  <= report_released;
    end
  end

  // --------------------------------------------------------------------------
  // data ready
  // --------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      ready_state <= idle;
    else
      ready_state <= ready_state_next;
  end

  // a report arriving in the same cycle as the read wins, so the fresh code
  // is not lost behind the read of the old one
  always_comb
  begin
    ready_state_next = ready_state;
    if (report_strobe)
      ready_state_next = holding;
    else if (rx_read)
      ready_state_next = idle;
  end

  assign rx_data_ready = (ready_state == holding);

  // data ready only comes up on the edge that also loads the registers
  a_ready_follows_report: assert property (
    @(posedge clk) disable iff (reset)
    $rose(rx_data_ready) |-> $past(report_strobe)
  );

endmodule

/* design/scan_code_decoder.sv */
`timescale 1ns/1ps

module scan_code_decoder #(
  parameter bit trap_shift_keys = 1'b0
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    frame_done,
  input  ps2_kbd_pkg::scan_code_t frame_code,
  output logic                    report_strobe,
  output ps2_kbd_pkg::scan_code_t report_code,
  output logic                    report_extended,
  output logic                    report_released,
  output logic                    shift_key_on
);

  import ps2_kbd_pkg::*;

  logic is_extend;
  logic is_release;
  logic is_prefix;
  logic is_left_shift;
  logic is_right_shift;
  logic code_event;
  logic hold_extended;
  logic hold_released;
  logic left_shift_key;
  logic right_shift_key;

  // --------------------------------------------------------------------------
  // code classification
  // --------------------------------------------------------------------------

  assign is_extend      = (frame_code == extend_code);
  assign is_release     = (frame_code == release_code);
  assign is_prefix      = is_extend || is_release;
  assign is_left_shift  = (frame_code == left_shift_code);
  assign is_right_shift = (frame_code == right_shift_code);

  // any completed code that is not a prefix ends a key sequence
  // this is true for a shift code too, reported or not, since the prefix
  // flags belong to it and must not leak onto the next key
  assign code_event = frame_done && !is_prefix;

  // --------------------------------------------------------------------------
  // prefix flags
  // --------------------------------------------------------------------------

  // E0 and F0 may both come ahead of one key, in that order, so the flags
  // are set one by one and only cleared together
  always_ff @(posedge clk)
  begin
    if (reset || code_event)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_extend)
        hold_extended <= 1'b1;
      if (is_release)
        hold_released <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // shift key tracking
  // --------------------------------------------------------------------------

  // a shift code without a release prefix is a press, with one a release
  // typematic repeats of a held shift key just set the bit again
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift_key  <= 1'b0;
      right_shift_key <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_left_shift)
        left_shift_key <= !hold_released;
      if (is_right_shift)
        right_shift_key <= !hold_released;
    end
  end

  // shift stays on until both keys are up
  assign shift_key_on = left_shift_key || right_shift_key;

  // --------------------------------------------------------------------------
  // report
  // --------------------------------------------------------------------------

  // shift codes can be kept off the output entirely, then only shift_key_on
  // tells about them
  assign report_strobe = code_event &&
                         !(trap_shift_keys && (is_left_shift || is_right_shift));

  // flags come from the held bits, which still show the prefixes seen
  // before this code and clear on the next edge
  assign report_code     = frame_code;
  assign report_extended = hold_extended;
  assign report_released = hold_released;

  // a prefix is never reported by itself, it shows up as a held flag that
  // is waiting for the key that follows
  a_prefix_held_not_reported: assert property (
    @(posedge clk) disable iff (reset)
    (frame_done && is_prefix) |-> !report_strobe ##1 (hold_extended || hold_released)
  );

endmodule

/* include/ps2_device_model.svh */
`ifndef PS2_DEVICE_MODEL_SVH
`define PS2_DEVICE_MODEL_SVH

// keyboard side of the PS/2 link, included inside the testbench module
// the tasks drive the testbench signals ps2_clk and ps2_data and time
// themselves on clk

// system clock cycles in one half period of the keyboard clock
localparam int ps2_half_period_cycles = 20;

// waits a number of clock edges, then steps 2 ns past the last one so that
// every change lands clear of the sampling edge
task automatic ps2_wait_cycles(input int cycles);
  repeat (cycles) @(posedge clk);
  #2;
endtask

// start bit low, data LSB first, odd parity, stop bit high
function automatic ps2_kbd_pkg::frame_t build_frame(input ps2_kbd_pkg::scan_code_t code);
  return {1'b1, ~^code, code, 1'b0};
endfunction

// plays the first bit_total bits of a frame
// data changes halfway through the high phase, then the clock pulses low
task automatic send_bits(input ps2_kbd_pkg::frame_t frame, input int bit_total);
  int i;
  for (i = 0; i < bit_total; i++)
  begin
    ps2_wait_cycles(ps2_half_period_cycles / 2);
    ps2_data = frame[i];
    ps2_wait_cycles(ps2_half_period_cycles / 2);
    ps2_clk = 1'b0;
    ps2_wait_cycles(ps2_half_period_cycles);
    ps2_clk = 1'b1;
  end
  // lines go back to idle high once the keyboard lets go
  ps2_data = 1'b1;
endtask

// a whole byte, with both lines left idle high afterwards
task automatic send_frame(input ps2_kbd_pkg::scan_code_t code);
  send_bits(build_frame(code), ps2_kbd_pkg::frame_bits);
endtask

`endif

/* dv/tb_ps2_kbd_rx.sv */
`timescale 1ns/1ps

module tb_ps2_kbd_rx;

  import ps2_kbd_pkg::*;

  // --------------------------------------------------------------------------
  // run length
  // --------------------------------------------------------------------------

  // frames sent over the whole run, with the broken frame of the idle test
  // counted as one
  localparam int frames_sent = 35;
  localparam int clock_period_ns = 20;
  // a keyboard bit takes two half periods of 20 clk cycles each
  localparam int bit_cycles = 40;
  localparam longint watchdog_ns = longint'(frames_sent) * frame_bits * bit_cycles *
                                   clock_period_ns + 50000;

  logic       clk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       rx_read;
  scan_code_t rx_scan_code;
  logic       rx_extended;
  logic       rx_released;
  logic       rx_shift_key_on;
  logic       rx_data_ready;

  ps2_kbd_rx #(
    .idle_timeout_cycles (100),
    .trap_shift_keys     (1'b1)
  ) i_dut (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_read         (rx_read),
    .rx_scan_code    (rx_scan_code),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_data_ready   (rx_data_ready)
  );

  // keyboard model, drives ps2_clk and ps2_data from the tasks below
  `include "ps2_device_model.svh"

  initial
  begin
    clk = 1'b0;
    forever #(clock_period_ns / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // checking helpers
  // --------------------------------------------------------------------------

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input string what,
                             input logic [7:0] expected, input logic [7:0] actual);
    string line;
    if (expected !== actual)
    begin
      line = $sformatf("[FAIL] %s: %s expected 0x%02h, actual 0x%02h",
                       test_name, what, expected, actual);
      fail_run(line);
    end
  endtask

  // data ready is normally up already when the last keyboard clock rises
  task automatic wait_ready(input string test_name);
    int n;
    n = 0;
    while (!rx_data_ready && n < 10)
    begin
      ps2_wait_cycles(1);
      n++;
    end
    if (!rx_data_ready)
      fail_run($sformatf("%s: data ready never came after the frame", test_name));
  endtask

  // one read pulse, ready has to be gone on the edge that took it
  task automatic pulse_read(input string test_name);
    rx_read = 1'b1;
    ps2_wait_cycles(1);
    rx_read = 1'b0;
    check_value(test_name, "rx_data_ready after read", 8'd0, 8'(rx_data_ready));
  endtask

  task automatic expect_report(input string test_name, input scan_code_t code,
                               input logic extended, input logic released);
    wait_ready(test_name);
    check_value(test_name, "rx_scan_code", code, rx_scan_code);
    check_value(test_name, "rx_extended", 8'(extended), 8'(rx_extended));
    check_value(test_name, "rx_released", 8'(released), 8'(rx_released));
  endtask

  // watches for a report that should never come
  task automatic expect_quiet(input string test_name, input int cycles);
    int n;
    for (n = 0; n < cycles; n++)
    begin
      check_value(test_name, "rx_data_ready", 8'd0, 8'(rx_data_ready));
      ps2_wait_cycles(1);
    end
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic plain_key();
    check_value("plain_key", "rx_scan_code at reset", 8'h00, rx_scan_code);
    check_value("plain_key", "rx_extended at reset", 8'd0, 8'(rx_extended));
    check_value("plain_key", "rx_released at reset", 8'd0, 8'(rx_released));
    check_value("plain_key", "rx_shift_key_on at reset", 8'd0, 8'(rx_shift_key_on));
    check_value("plain_key", "rx_data_ready at reset", 8'd0, 8'(rx_data_ready));
    send_frame(8'h1C);
    expect_report("plain_key", 8'h1C, 1'b0, 1'b0);
    pulse_read("plain_key");
  endtask

  // the two prefixes must fold into flags of the one code after them
  task automatic prefixed_release();
    send_frame(8'hE0);
    expect_quiet("prefixed_release", 2);
    send_frame(8'hF0);
    expect_quiet("prefixed_release", 2);
    send_frame(8'h75);
    expect_report("prefixed_release", 8'h75, 1'b1, 1'b1);
    pulse_read("prefixed_release");
    send_frame(8'h1C);
    expect_report("prefixed_release", 8'h1C, 1'b0, 1'b0);
    pulse_read("prefixed_release");
  endtask

  task automatic shift_tracking();
    send_frame(8'h12);
    check_value("shift_tracking", "shift on after left press", 8'd1, 8'(rx_shift_key_on));
    expect_quiet("shift_tracking", 60);
    // right key let go while left stays down
    send_frame(8'hF0);
    send_frame(8'h59);
    check_value("shift_tracking", "shift on after right release", 8'd1,
                8'(rx_shift_key_on));
    expect_quiet("shift_tracking", 4);
    send_frame(8'hF0);
    send_frame(8'h12);
    check_value("shift_tracking", "shift on after left release", 8'd0,
                8'(rx_shift_key_on));
    expect_quiet("shift_tracking", 4);
    // the release flag went with the trapped code and must not stick
    send_frame(8'h1C);
    expect_report("shift_tracking", 8'h1C, 1'b0, 1'b0);
    pulse_read("shift_tracking");
  endtask

  task automatic idle_watchdog();
    send_bits(build_frame(8'h2A), 5);
    ps2_wait_cycles(150);
    check_value("idle_watchdog", "rx_data_ready after broken frame", 8'd0,
                8'(rx_data_ready));
    send_frame(8'h2A);
    expect_report("idle_watchdog", 8'h2A, 1'b0, 1'b0);
    pulse_read("idle_watchdog");
  endtask

  task automatic no_back_pressure();
    send_frame(8'h15);
    wait_ready("no_back_pressure");
    send_frame(8'h16);
    check_value("no_back_pressure", "rx_data_ready", 8'd1, 8'(rx_data_ready));
    expect_report("no_back_pressure", 8'h16, 1'b0, 1'b0);
    pulse_read("no_back_pressure");
  endtask

  task automatic random_codes();
    scan_code_t code;
    int n;
    for (n = 0; n < 20; n++)
    begin
      code = 8'($urandom);
      // prefixes and shift codes are never reported as they are
      while (code == extend_code || code == release_code ||
             code == left_shift_code || code == right_shift_code)
        code = 8'($urandom);
      send_frame(code);
      expect_report("random_codes", code, 1'b0, 1'b0);
      pulse_read("random_codes");
    end
  endtask

  // --------------------------------------------------------------------------
  // run control
  // --------------------------------------------------------------------------

  initial
  begin
    #(watchdog_ns);
    fail_run("timeout: the tests did not finish in the expected time");
  end

  initial
  begin
    reset = 1'b1;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    rx_read = 1'b0;
    void'($urandom(69));
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    ps2_wait_cycles(4);
    plain_key();
    prefixed_release();
    shift_tracking();
    idle_watchdog();
    no_back_pressure();
    random_codes();
    $display("All tests passed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
design/ps2_kbd_pkg.sv
design/ps2_frame_receiver.sv
design/scan_code_decoder.sv
design/rx_output_register.sv
design/ps2_kbd_rx.sv
dv/tb_ps2_kbd_rx.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ps2_kbd_rx \
  -f filelist.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Some tests failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
